//--- common/core_pkg.sv
// core-wide data widths and the load width opcode imported by every load path block
package core_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////
    localparam int xlen    = 32;  // data and address width
    localparam int prf_len = 6;   // physical register tag
    localparam int rob_len = 5;   // rob index

    // major opcode shared by all rv32 loads
    localparam logic [6:0] load_opcode = 7'b0000011;

    ////////////////////////////////////////////////////////////
    // load width encoded as funct3
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        op_lb  = 3'b000,
        op_lh  = 3'b001,
        op_lw  = 3'b010,
        op_lbu = 3'b100,
        op_lhu = 3'b101
    } load_op_e;

endpackage

//--- common/load_pkg.sv
// sizes of the load reservation station and of the data table behind the load unit
package load_pkg;

    ////////////////////////////////////////////////////////////
    // reservation station
    ////////////////////////////////////////////////////////////
    localparam int rs_lb_size = 4;  // slots
    localparam int rs_lb_len  = 2;  // slot index width

    ////////////////////////////////////////////////////////////
    // data table
    ////////////////////////////////////////////////////////////
    // byte at address a is a[7:0] ^ 8'h5a with wrapping addresses
    localparam int mem_bytes = 256;
    localparam int mem_len   = 8;

endpackage

//--- rs_lb/psel_gen.sv
// lowest-index-first one-hot selector with empty flag that picks the issuing station slot
`timescale 1ns/1ps

module psel_gen #(
    parameter int width = 4
) (
    input  logic [width-1:0] req,
    output logic [width-1:0] gnt,
    output logic             empty
);

    logic [width-1:0] req_neg;  // two's complement of req

    // isolating the lowest set bit gives the grant
    assign req_neg = ~req + width'(1);
    assign gnt     = req & req_neg;

    assign empty = ~|req;  // nothing to grant

endmodule

//--- rs_lb/rs_lb.sv
// load reservation station holding loads until cdb wakeup and issuing one per cycle
`timescale 1ns/1ps

module rs_lb import core_pkg::*, load_pkg::*; (
    input  logic               clock,
    input  logic               arst_n,
    // dispatch from the decoder
    input  logic               dispatch,
    input  logic [prf_len-1:0] base_preg,
    input  logic               base_ready,
    input  logic [xlen-1:0]    base_value,
    input  logic [xlen-1:0]    offset,
    input  load_op_e           load_op,
    input  logic [prf_len-1:0] dest_preg,
    input  logic [rob_len-1:0] rob_idx,
    // common data bus
    input  logic               cdb_valid,
    input  logic [prf_len-1:0] cdb_tag,
    input  logic [xlen-1:0]    cdb_value,
    input  logic               flush,       // commit-time mispredict
    output logic               rs_full,
    // issue to the load unit
    output logic               issue_valid,
    output logic [xlen-1:0]    issue_base,
    output logic [xlen-1:0]    issue_offset,
    output load_op_e           issue_op,
    output logic [prf_len-1:0] issue_tag,
    output logic [rob_len-1:0] issue_rob
);

    ////////////////////////////////////////////////////////////
    // slot storage
    ////////////////////////////////////////////////////////////
    logic [rs_lb_size-1:0] free;   // slot is empty
    logic [rs_lb_size-1:0] ready;  // base value captured
    logic [prf_len-1:0]    base_tag [rs_lb_size];
    logic [xlen-1:0]       base_val [rs_lb_size];
    logic [xlen-1:0]       off      [rs_lb_size];
    load_op_e              op       [rs_lb_size];
    logic [prf_len-1:0]    dest     [rs_lb_size];
    logic [rob_len-1:0]    rob      [rs_lb_size];

    logic [rs_lb_len:0]    count;     // occupied slots
    logic [rs_lb_len-1:0]  free_idx;  // where the next dispatch lands
    logic [rs_lb_len-1:0]  sel_idx;   // slot picked for issue
    logic [rs_lb_size-1:0] ex_req;
    logic [rs_lb_size-1:0] gnt;
    logic                  none_ready;
    logic                  issue_go;
    logic                  wake_new;  // broadcast hits the load being dispatched

    assign rs_full  = (count == (rs_lb_len+1)'(rs_lb_size));
    assign issue_go = ~none_ready;
    assign wake_new = cdb_valid && (cdb_tag == base_preg);

    // first free slot, low to high
    always_comb begin
        free_idx = '0;
        for (int i = rs_lb_size-1; i >= 0; i--) begin
            if (free[i]) free_idx = rs_lb_len'(i);
        end
    end

    assign ex_req = ~free & ready;  // occupied and ready

    psel_gen #(.width(rs_lb_size)) u_psel (
        .req   (ex_req),
        .gnt   (gnt),
        .empty (none_ready)
    );

    always_comb begin
        sel_idx = '0;
        for (int j = 0; j < rs_lb_size; j++) begin
            if (gnt[j]) sel_idx = rs_lb_len'(j);
        end
    end

    ////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            free        <= '1;
            ready       <= '0;
            count       <= '0;
            issue_valid <= 1'b0;
        end else if (flush) begin
            free        <= '1;  // dispatch this cycle is dropped too
            ready       <= '0;
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            count       <= count + (rs_lb_len+1)'(dispatch) - (rs_lb_len+1)'(issue_go);
            issue_valid <= issue_go;
            if (cdb_valid) begin
                for (int t = 0; t < rs_lb_size; t++) begin
                    if (!free[t] && !ready[t] && base_tag[t] == cdb_tag) ready[t] <= 1'b1;
                end
            end
            if (issue_go) free[sel_idx] <= 1'b1;  // reusable from the next cycle
            if (dispatch) begin
                free[free_idx]  <= 1'b0;
                ready[free_idx] <= base_ready || wake_new;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (cdb_valid) begin
            for (int t = 0; t < rs_lb_size; t++) begin
                if (!free[t] && !ready[t] && base_tag[t] == cdb_tag) base_val[t] <= cdb_value;
            end
        end
        if (dispatch) begin
            base_tag[free_idx] <= base_preg;
            base_val[free_idx] <= base_ready ? base_value : cdb_value;
            off[free_idx]      <= offset;
            op[free_idx]       <= load_op;
            dest[free_idx]     <= dest_preg;
            rob[free_idx]      <= rob_idx;
        end
        if (issue_go) begin
            issue_base   <= base_val[sel_idx];
            issue_offset <= off[sel_idx];
            issue_op     <= op[sel_idx];
            issue_tag    <= dest[sel_idx];
            issue_rob    <= rob[sel_idx];
        end
    end

endmodule

//--- hdl/load_decode.sv
// load decoder turning a renamed I-type word into a dispatch or an illegal strobe
`timescale 1ns/1ps

module load_decode import core_pkg::*; (
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    input  logic            rs_full,
    output logic            dispatch,
    output logic            illegal,
    output logic [xlen-1:0] offset,
    output load_op_e        load_op
);

    logic is_load;
    logic width_ok;  // funct3 names a real load width

    assign is_load = (instr[6:0] == load_opcode);

    // 12-bit immediate, sign extended
    assign offset = {{(xlen-12){instr[31]}}, instr[31:20]};

    always_comb begin
        width_ok = 1'b1;
        case (instr[14:12])
            3'b000:  load_op = op_lb;
            3'b001:  load_op = op_lh;
            3'b010:  load_op = op_lw;
            3'b100:  load_op = op_lbu;
            3'b101:  load_op = op_lhu;
            default: begin  // 3, 6 and 7
                load_op  = op_lb;
                width_ok = 1'b0;
            end
        endcase
    end

    // a full station drops the load and the producer retries
    assign dispatch = instr_valid && is_load && width_ok && !rs_full;
    assign illegal  = instr_valid && !(is_load && width_ok);

endmodule

//--- hdl/load_unit.sv
// two-stage load unit that adds the address and reads the data table with sign or zero extension
`timescale 1ns/1ps

module load_unit import core_pkg::*, load_pkg::*; (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               flush,
    input  logic               issue_valid,
    input  logic [xlen-1:0]    issue_base,
    input  logic [xlen-1:0]    issue_offset,
    input  load_op_e           issue_op,
    input  logic [prf_len-1:0] issue_tag,
    input  logic [rob_len-1:0] issue_rob,
    output logic               result_valid,
    output logic [prf_len-1:0] result_tag,
    output logic [rob_len-1:0] result_rob,
    output logic [xlen-1:0]    result_value
);

    logic [7:0]         table_q [mem_bytes];  // fixed contents
    logic [xlen-1:0]    eff_addr;
    logic               s1_valid;
    logic [mem_len-1:0] s1_addr;
    load_op_e           s1_op;
    logic [prf_len-1:0] s1_tag;
    logic [rob_len-1:0] s1_rob;
    logic [7:0]         b0, b1, b2, b3;
    logic [xlen-1:0]    load_data;

    always_comb begin
        for (int a = 0; a < mem_bytes; a++) begin
            table_q[a] = 8'(a) ^ 8'h5a;
        end
    end

    assign eff_addr = issue_base + issue_offset;

    // little endian with byte addresses wrapping in the table
    assign b0 = table_q[s1_addr];
    assign b1 = table_q[s1_addr + mem_len'(1)];
    assign b2 = table_q[s1_addr + mem_len'(2)];
    assign b3 = table_q[s1_addr + mem_len'(3)];

    always_comb begin
        case (s1_op)
            op_lb:   load_data = {{(xlen-8){b0[7]}}, b0};
            op_lh:   load_data = {{(xlen-16){b1[7]}}, b1, b0};
            op_lbu:  load_data = {{(xlen-8){1'b0}}, b0};
            op_lhu:  load_data = {{(xlen-16){1'b0}}, b1, b0};
            default: load_data = {b3, b2, b1, b0};  // lw
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= issue_valid && !flush;
            result_valid <= s1_valid && !flush;
        end
    end

    always_ff @(posedge clock) begin
        s1_addr      <= eff_addr[mem_len-1:0];
        s1_op        <= issue_op;
        s1_tag       <= issue_tag;
        s1_rob       <= issue_rob;
        result_tag   <= s1_tag;
        result_rob   <= s1_rob;
        result_value <= load_data;
    end

endmodule

//--- hdl/load_issue_top.sv
// load issue path top chaining decoder, reservation station and load unit
`timescale 1ns/1ps

module load_issue_top import core_pkg::*; (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               instr_valid,
    input  logic [31:0]        instr,
    input  logic [prf_len-1:0] base_preg,
    input  logic               base_ready,
    input  logic [xlen-1:0]    base_value,
    input  logic [prf_len-1:0] dest_preg,
    input  logic [rob_len-1:0] rob_idx,
    input  logic               cdb_valid,
    input  logic [prf_len-1:0] cdb_tag,
    input  logic [xlen-1:0]    cdb_value,
    input  logic               flush,
    output logic               rs_full,
    output logic               illegal,
    output logic               result_valid,
    output logic [prf_len-1:0] result_tag,
    output logic [rob_len-1:0] result_rob,
    output logic [xlen-1:0]    result_value
);

    logic               dispatch;
    logic [xlen-1:0]    offset;
    load_op_e           load_op;
    logic               issue_valid;
    logic [xlen-1:0]    issue_base;
    logic [xlen-1:0]    issue_offset;
    load_op_e           issue_op;
    logic [prf_len-1:0] issue_tag;
    logic [rob_len-1:0] issue_rob;

    load_decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_full     (rs_full),
        .dispatch    (dispatch),
        .illegal     (illegal),
        .offset      (offset),
        .load_op     (load_op)
    );

    rs_lb u_rs_lb (
        .clock        (clock),
        .arst_n       (arst_n),
        .dispatch     (dispatch),
        .base_preg    (base_preg),
        .base_ready   (base_ready),
        .base_value   (base_value),
        .offset       (offset),
        .load_op      (load_op),
        .dest_preg    (dest_preg),
        .rob_idx      (rob_idx),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .flush        (flush),
        .rs_full      (rs_full),
        .issue_valid  (issue_valid),
        .issue_base   (issue_base),
        .issue_offset (issue_offset),
        .issue_op     (issue_op),
        .issue_tag    (issue_tag),
        .issue_rob    (issue_rob)
    );

    load_unit u_load_unit (
        .clock        (clock),
        .arst_n       (arst_n),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_base   (issue_base),
        .issue_offset (issue_offset),
        .issue_op     (issue_op),
        .issue_tag    (issue_tag),
        .issue_rob    (issue_rob),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_rob   (result_rob),
        .result_value (result_value)
    );

endmodule

//--- test/load_issue_sva.sv
// concurrent checks on the load reservation station bound into every rs_lb instance
`timescale 1ns/1ps

module load_issue_sva import load_pkg::*; (
    input logic               clock,
    input logic               arst_n,
    input logic               dispatch,
    input logic               flush,
    input logic               rs_full,
    input logic               issue_valid,
    input logic [rs_lb_len:0] count
);

    // a flush kills whatever was about to issue
    a_flush_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        flush |=> !issue_valid) else $error("issue_valid high after flush");

    a_full_blocks: assert property (@(posedge clock) disable iff (!arst_n)
        !(rs_full && dispatch)) else $error("dispatch while station full");

    a_count_range: assert property (@(posedge clock) disable iff (!arst_n)
        count <= (rs_lb_len+1)'(rs_lb_size)) else $error("occupancy above station size");

    a_reset_quiet: assert property (@(posedge clock)
        !arst_n |-> !issue_valid) else $error("issue_valid high in reset");

endmodule

bind rs_lb load_issue_sva u_sva (
    .clock       (clock),
    .arst_n      (arst_n),
    .dispatch    (dispatch),
    .flush       (flush),
    .rs_full     (rs_full),
    .issue_valid (issue_valid),
    .count       (count)
);

//--- test/load_issue_tb.sv
// testbench running a table of loads, wakeups and flushes through the load issue top
`timescale 1ns/1ps

module load_issue_tb import core_pkg::*, load_pkg::*;;

    localparam int act_ld = 0, act_wk = 1, act_fl = 2, act_dr = 3;  // row actions
    localparam int out_none = 0, out_res = 1, out_ill = 2;           // expected outcome

    typedef struct packed {
        logic [2:0] test;
        logic [1:0] act;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       rdy;
        logic       same;   // cdb hits the base tag in the dispatch cycle
        logic [5:0] preg;
        logic [4:0] rob;
        logic [1:0] exp;
        logic       full;   // rs_full expected at dispatch
    } row_t;

    logic clock, arst_n, instr_valid, base_ready, cdb_valid, flush;
    logic [31:0] instr, base_value, cdb_value;
    logic [prf_len-1:0] base_preg, dest_preg, cdb_tag;
    logic [rob_len-1:0] rob_idx;
    logic rs_full, illegal, result_valid;
    logic [prf_len-1:0] result_tag;
    logic [rob_len-1:0] result_rob;
    logic [xlen-1:0] result_value;

    // scoreboard keyed by rob index
    logic pending [32];
    logic known [32];
    logic [31:0] exp_val [32];
    logic [31:0] offs [32];
    logic [5:0] exp_tag [32];
    logic [5:0] btag [32];
    logic [2:0] f3s [32];
    int exp_cyc [32];
    int pending_cnt = 0, cyc = 0, test_errs = 0, total_errs = 0, passed = 0, failed = 0;
    logic [31:0] rng = 32'd2;
    row_t rows [$];

    load_issue_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) cyc++;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // table byte is address ^ 5a read little endian and wrapping in 256 bytes
    function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] addr);
        logic [7:0] b [4];
        for (int k = 0; k < 4; k++) b[k] = (addr[7:0] + 8'(k)) ^ 8'h5a;
        case (f3)
            3'd0:    return {{24{b[0][7]}}, b[0]};
            3'd1:    return {{16{b[1][7]}}, b[1], b[0]};
            3'd2:    return {b[3], b[2], b[1], b[0]};
            3'd4:    return {24'd0, b[0]};
            default: return {16'd0, b[1], b[0]};
        endcase
    endfunction

    function automatic row_t make_row(input int test, act, opc, f3, rdy, same, preg, rob,
                                      exp, full);
        row_t r;
        r = '{test[2:0], act[1:0], opc[6:0], f3[2:0], rdy[0], same[0], preg[5:0], rob[4:0],
              exp[1:0], full[0]};
        return r;
    endfunction

    task automatic note_error();
        test_errs++;
        total_errs++;
    endtask

    always @(negedge clock) begin
        int r;
        if (arst_n && result_valid) begin
            r = result_rob;
            assert (pending[r] && known[r]) else begin
                $display("unexpected result for rob %0d", r);
                note_error();
            end
            if (pending[r]) begin
                assert (result_value == exp_val[r]) else begin
                    $display("FAILED result_value rob %0d: got %h expected %h", r,
                             result_value, exp_val[r]);
                    note_error();
                end
                assert (result_tag == exp_tag[r]) else begin
                    $display("FAILED result_tag rob %0d: got %h expected %h", r,
                             result_tag, exp_tag[r]);
                    note_error();
                end
                if (exp_cyc[r] != 0) begin
                    assert (cyc == exp_cyc[r]) else begin
                        $display("rob %0d finished at cycle %0d instead of %0d", r, cyc,
                                 exp_cyc[r]);
                        note_error();
                    end
                end
                pending[r] = 1'b0;
                pending_cnt--;
            end
        end
    end

    task automatic wake(input logic [5:0] tag, input logic [31:0] value);
        for (int r = 0; r < 32; r++) begin
            if (pending[r] && !known[r] && btag[r] == tag) begin
                exp_val[r] = load_ref(f3s[r], value + offs[r]);
                known[r]   = 1'b1;
            end
        end
    endtask

    task automatic drain(input int test);
        int t;
        t = 0;
        while (pending_cnt > 0 && t < 100) begin
            @(posedge clock);
            t++;
        end
        if (pending_cnt > 0) begin
            $display("timeout with %0d results still outstanding in test %0d", pending_cnt, test);
            $display("tests failed");
            $finish;
        end
        repeat (10) @(posedge clock);  // quiet window for stray results
        if (test_errs == 0) begin
            $display("test %0d: ok", test);
            passed++;
        end else begin
            $display("test %0d: fail, %0d errors", test, test_errs);
            failed++;
        end
        test_errs = 0;
    endtask

    task automatic apply_row(input row_t rw);
        logic [31:0] bval;
        logic [11:0] imm;
        @(posedge clock);
        #2;
        instr_valid = 1'b0;
        cdb_valid   = 1'b0;
        flush       = 1'b0;
        base_ready  = 1'b0;
        rng  = xorshift(rng);
        bval = rng;
        rng  = xorshift(rng);
        imm  = rng[11:0];
        case (rw.act)
            act_ld: begin
                instr       = {imm, 5'd1, rw.f3, 5'd2, rw.opc};
                instr_valid = 1'b1;
                base_preg   = rw.preg;
                base_ready  = rw.rdy;
                base_value  = rw.rdy ? bval : ~bval;
                dest_preg   = {1'b1, rw.rob};
                rob_idx     = rw.rob;
                if (rw.same) begin
                    cdb_valid = 1'b1;
                    cdb_tag   = rw.preg;
                    cdb_value = bval;
                end
                #1;
                assert (rs_full == rw.full) else begin
                    $display("FAILED rs_full: got %h expected %h", rs_full, rw.full);
                    note_error();
                end
                assert (illegal == (rw.exp == out_ill)) else begin
                    $display("FAILED illegal: got %h expected %h", illegal, rw.exp == out_ill);
                    note_error();
                end
                if (rw.exp == out_res) begin
                    pending[rw.rob] = 1'b1;
                    known[rw.rob]   = rw.rdy || rw.same;
                    offs[rw.rob]    = {{20{imm[11]}}, imm};
                    f3s[rw.rob]     = rw.f3;
                    btag[rw.rob]    = rw.preg;
                    exp_tag[rw.rob] = {1'b1, rw.rob};
                    exp_val[rw.rob] = load_ref(rw.f3, bval + {{20{imm[11]}}, imm});
                    exp_cyc[rw.rob] = (rw.test == 1) ? cyc + 4 : 0;  // 3 cycles after acceptance
                    pending_cnt++;
                end
            end
            act_wk: begin
                cdb_valid = 1'b1;
                cdb_tag   = rw.preg;
                cdb_value = bval;
                wake(rw.preg, bval);
            end
            act_fl: begin
                flush = 1'b1;
                for (int r = 0; r < 32; r++) pending[r] = 1'b0;
                pending_cnt = 0;
            end
            default: drain(rw.test);
        endcase
    endtask

    initial begin
        {instr_valid, base_ready, cdb_valid, flush} = '0;
        {instr, base_value, cdb_value, base_preg, dest_preg, cdb_tag, rob_idx} = '0;
        arst_n = 1'b0;
        for (int r = 0; r < 32; r++) pending[r] = 1'b0;
        // ready loads of every width
        rows.push_back(make_row(1, act_ld, 7'h03, 0, 1, 0, 1, 1, out_res, 0));
        rows.push_back(make_row(1, act_ld, 7'h03, 1, 1, 0, 2, 2, out_res, 0));
        rows.push_back(make_row(1, act_ld, 7'h03, 2, 1, 0, 3, 3, out_res, 0));
        rows.push_back(make_row(1, act_ld, 7'h03, 4, 1, 0, 4, 4, out_res, 0));
        rows.push_back(make_row(1, act_ld, 7'h03, 5, 1, 0, 5, 5, out_res, 0));
        rows.push_back(make_row(1, act_dr, 0, 0, 0, 0, 0, 0, out_none, 0));
        // cdb wakeup with one hit in the dispatch cycle
        rows.push_back(make_row(2, act_ld, 7'h03, 2, 0, 0, 10, 6, out_res, 0));
        rows.push_back(make_row(2, act_ld, 7'h03, 0, 0, 0, 11, 7, out_res, 0));
        rows.push_back(make_row(2, act_ld, 7'h03, 5, 0, 1, 12, 8, out_res, 0));
        rows.push_back(make_row(2, act_wk, 0, 0, 0, 0, 10, 0, out_none, 0));
        rows.push_back(make_row(2, act_wk, 0, 0, 0, 0, 11, 0, out_none, 0));
        rows.push_back(make_row(2, act_dr, 0, 0, 0, 0, 0, 0, out_none, 0));
        // station full so the fifth load is dropped
        for (int k = 0; k < 4; k++) begin
            rows.push_back(make_row(3, act_ld, 7'h03, 2, 0, 0, 20+k, 9+k, out_res, 0));
        end
        rows.push_back(make_row(3, act_ld, 7'h03, 2, 0, 0, 24, 13, out_none, 1));
        for (int k = 0; k < 5; k++) begin
            rows.push_back(make_row(3, act_wk, 0, 0, 0, 0, 20+k, 0, out_none, 0));
        end
        rows.push_back(make_row(3, act_dr, 0, 0, 0, 0, 0, 0, out_none, 0));
        // illegal words
        rows.push_back(make_row(4, act_ld, 7'h13, 0, 1, 0, 25, 18, out_ill, 0));
        rows.push_back(make_row(4, act_ld, 7'h03, 7, 1, 0, 26, 19, out_ill, 0));
        rows.push_back(make_row(4, act_dr, 0, 0, 0, 0, 0, 0, out_none, 0));
        // flush with a full station and one load in the load unit
        rows.push_back(make_row(5, act_ld, 7'h03, 1, 0, 0, 30, 15, out_none, 0));
        rows.push_back(make_row(5, act_ld, 7'h03, 4, 0, 0, 31, 16, out_none, 0));
        rows.push_back(make_row(5, act_ld, 7'h03, 2, 1, 0, 27, 14, out_none, 0));
        rows.push_back(make_row(5, act_ld, 7'h03, 0, 0, 0, 33, 20, out_none, 0));
        rows.push_back(make_row(5, act_ld, 7'h03, 5, 0, 0, 34, 21, out_none, 0));
        rows.push_back(make_row(5, act_fl, 0, 0, 0, 0, 0, 0, out_none, 0));
        rows.push_back(make_row(5, act_wk, 0, 0, 0, 0, 30, 0, out_none, 0));
        rows.push_back(make_row(5, act_ld, 7'h03, 2, 1, 0, 32, 17, out_res, 0));
        rows.push_back(make_row(5, act_dr, 0, 0, 0, 0, 0, 0, out_none, 0));

        repeat (10) @(posedge clock);
        #2 arst_n = 1'b1;
        foreach (rows[i]) apply_row(rows[i]);

        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, total_errs);
        if (failed == 0 && total_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- load_issue.f
common/core_pkg.sv
common/load_pkg.sv
rs_lb/psel_gen.sv
rs_lb/rs_lb.sv
hdl/load_decode.sv
hdl/load_unit.sv
hdl/load_issue_top.sv
test/load_issue_sva.sv
test/load_issue_tb.sv

//--- Makefile
# Verilator build and run for the load issue path

VERILATOR ?= verilator
TOP       ?= load_issue_tb
FLIST     ?= load_issue.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
